/* compile.f */
+incdir+hdl
hdl/lc4_pkg.sv
hdl/lc4_decoder.sv
hdl/lc4_regfile.sv
hdl/lc4_alu.sv
hdl/lc4_hazard_unit.sv
hdl/lc4_pipeline.sv
bench/lc4_pipeline_properties.sv
bench/lc4_pipeline_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module lc4_pipeline_tb &&
./obj_dir/Vlc4_pipeline_tb || exit 1

/* bench/lc4_pipeline_tb.sv */
`timescale 1ns/1ns
`include "lc4_params.svh"

module lc4_pipeline_tb;

    localparam int num_rows       = 19;
    localparam int timeout_cycles = num_rows * 4 + 40;

    // one program slot and what it should leave in the trace
    typedef struct packed {
        lc4_pkg::word_t    insn;
        logic              retire;
        logic              rf_we;
        lc4_pkg::reg_sel_t wsel;
        lc4_pkg::word_t    wdata;
        lc4_pkg::word_t    mem_addr;
        lc4_pkg::word_t    mem_data;
        logic [1:0]        n_load;
        logic [1:0]        n_branch;
    } row_t;

    // insn, retire, rf_we, wsel, wdata, mem addr, mem data, load bubbles, branch bubbles
    localparam row_t prog_rows [num_rows] = '{
        '{16'h9205, 1'b1, 1'b1, 3'd1, 16'h0005, 16'h0000, 16'h0000, 2'd0, 2'd0},
        '{16'h9403, 1'b1, 1'b1, 3'd2, 16'h0003, 16'h0000, 16'h0000, 2'd0, 2'd0},
        '{16'h1642, 1'b1, 1'b1, 3'd3, 16'h0008, 16'h0000, 16'h0000, 2'd0, 2'd0},
        '{16'h18D1, 1'b1, 1'b1, 3'd4, 16'h0003, 16'h0000, 16'h0000, 2'd0, 2'd0},
        '{16'h5B03, 1'b1, 1'b1, 3'd5, 16'h0000, 16'h0000, 16'h0000, 2'd0, 2'd0},
        '{16'h1D7D, 1'b1, 1'b1, 3'd6, 16'hFFFD, 16'h0000, 16'h0000, 2'd0, 2'd0},
        '{16'h9E40, 1'b1, 1'b1, 3'd7, 16'h0040, 16'h0000, 16'h0000, 2'd0, 2'd0},
        '{16'h63C1, 1'b1, 1'b1, 3'd1, 16'hA582, 16'h0041, 16'hA582, 2'd0, 2'd0},
        '{16'h73C0, 1'b1, 1'b0, 3'd0, 16'h0000, 16'h0040, 16'hA582, 2'd0, 2'd0},
        '{16'h65C0, 1'b1, 1'b1, 3'd2, 16'hA582, 16'h0040, 16'hA582, 2'd0, 2'd0},
        '{16'h1682, 1'b1, 1'b1, 3'd3, 16'h4B04, 16'h0000, 16'h0000, 2'd1, 2'd0},
        '{16'h69C2, 1'b1, 1'b1, 3'd4, 16'hA581, 16'h0042, 16'hA581, 2'd0, 2'd0},
        '{16'h0802, 1'b1, 1'b0, 3'd0, 16'h0000, 16'h0000, 16'h0000, 2'd1, 2'd0},
        '{16'h9A11, 1'b0, 1'b1, 3'd5, 16'h0011, 16'h0000, 16'h0000, 2'd0, 2'd0},
        '{16'h9A22, 1'b0, 1'b1, 3'd5, 16'h0022, 16'h0000, 16'h0000, 2'd0, 2'd0},
        '{16'h9A07, 1'b1, 1'b1, 3'd5, 16'h0007, 16'h0000, 16'h0000, 2'd0, 2'd2},
        '{16'h0801, 1'b1, 1'b0, 3'd0, 16'h0000, 16'h0000, 16'h0000, 2'd0, 2'd0},
        '{16'h1D61, 1'b1, 1'b1, 3'd6, 16'h0008, 16'h0000, 16'h0000, 2'd0, 2'd0},
        '{16'h5F85, 1'b1, 1'b1, 3'd7, 16'h0000, 16'h0000, 16'h0000, 2'd0, 2'd0}
    };

    logic               gwe;
    logic               rst_n;
    lc4_pkg::word_t     cur_pc;
    lc4_pkg::word_t     cur_insn;
    lc4_pkg::dmem_req_t dmem_req;
    lc4_pkg::dmem_req_t pend_req;
    lc4_pkg::word_t     dmem_rdata;
    lc4_pkg::trace_t    trace;
    lc4_pkg::word_t     data_mem [65536];
    int                 cycles;
    int                 row;
    int                 loads_seen;
    int                 branches_seen;

    lc4_pipeline i_dut (
        .gwe         (gwe),
        .i_rst_n     (rst_n),
        .o_cur_pc    (cur_pc),
        .i_cur_insn  (cur_insn),
        .o_dmem      (dmem_req),
        .i_dmem_data (dmem_rdata),
        .o_trace     (trace)
    );

    bind lc4_pipeline lc4_pipeline_properties u_properties (
        .gwe     (gwe),
        .i_rst_n (i_rst_n),
        .i_dmem  (o_dmem),
        .i_trace (o_trace)
    );

    function automatic lc4_pkg::word_t fetch_insn(input lc4_pkg::word_t pc);
        lc4_pkg::word_t offset;
        offset = pc - `LC4_RESET_PC;
        // outside the program the core sees BR with nzp 000
        if (offset < num_rows) begin
            return prog_rows[offset].insn;
        end
        return 16'h0000;
    endfunction

    function automatic lc4_pkg::nzp_t expected_nzp(input lc4_pkg::word_t value);
        return {value[`LC4_WORD_W-1], value == 16'd0, !value[`LC4_WORD_W-1] && value != 16'd0};
    endfunction

    task automatic check_value(input string name, input lc4_pkg::word_t expected,
                               input lc4_pkg::word_t actual);
        if (expected !== actual) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_retired(input int idx);
        row_t       exp;
        string      tag;
        logic [3:0] opcode;
        exp    = prog_rows[idx];
        tag    = $sformatf("row %0d", idx);
        opcode = exp.insn[15:12];
        check_value({tag, " pc"}, lc4_pkg::word_t'(`LC4_RESET_PC + idx), trace.pc);
        check_value({tag, " insn"}, exp.insn, trace.insn);
        check_value({tag, " regfile_we"}, 16'(exp.rf_we), 16'(trace.regfile_we));
        // every register write in this subset also sets nzp
        check_value({tag, " nzp_we"}, 16'(exp.rf_we), 16'(trace.nzp_we));
        if (exp.rf_we) begin
            check_value({tag, " wsel"}, 16'(exp.wsel), 16'(trace.wsel));
            check_value({tag, " wdata"}, exp.wdata, trace.wdata);
            check_value({tag, " nzp_bits"}, 16'(expected_nzp(exp.wdata)), 16'(trace.nzp_bits));
        end
        check_value({tag, " dmem_we"}, 16'(opcode == `LC4_OP_STR), 16'(trace.dmem_we));
        if (opcode == `LC4_OP_LDR || opcode == `LC4_OP_STR) begin
            check_value({tag, " dmem_addr"}, exp.mem_addr, trace.dmem_addr);
            check_value({tag, " dmem_data"}, exp.mem_data, trace.dmem_data);
        end
        // the reset bubbles ahead of the first retire are not counted
        if (idx > 0) begin
            check_value({tag, " load bubbles"}, 16'(exp.n_load), 16'(loads_seen));
            check_value({tag, " branch bubbles"}, 16'(exp.n_branch), 16'(branches_seen));
        end
    endtask

    always #20 gwe = ~gwe;

    // the write from the previous cycle lands before the read so a following load sees it
    always @(posedge gwe) begin
        #2;
        if (pend_req.we) begin
            data_mem[pend_req.addr] = pend_req.towrite;
        end
        cur_insn   = fetch_insn(cur_pc);
        dmem_rdata = data_mem[dmem_req.addr];
    end

    always @(negedge gwe) begin
        pend_req = dmem_req;
        if (rst_n) begin
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("timeout, the program did not retire within %0d cycles",
                         timeout_cycles);
                $display("Some tests failed");
                $fatal(1, "timeout");
            end
            if (trace.stall != lc4_pkg::STALL_NONE) begin
                check_value("bubble regfile_we", 16'd0, 16'(trace.regfile_we));
                check_value("bubble nzp_we", 16'd0, 16'(trace.nzp_we));
                check_value("bubble dmem_we", 16'd0, 16'(trace.dmem_we));
                if (trace.stall == lc4_pkg::STALL_LOAD) begin
                    loads_seen++;
                end else if (trace.stall == lc4_pkg::STALL_BRANCH) begin
                    branches_seen++;
                end
            end else begin
                // flushed slots are passed over
                while (row < num_rows && !prog_rows[row].retire) begin
                    row++;
                end
                check_retired(row);
                row++;
                loads_seen    = 0;
                branches_seen = 0;
                if (row >= num_rows) begin
                    $display("All tests passed");
                    $finish;
                end
            end
        end
    end

    initial begin
        gwe           = 1'b0;
        rst_n         = 1'b0;
        cur_insn      = '0;
        dmem_rdata    = '0;
        pend_req      = '0;
        cycles        = 0;
        row           = 0;
        loads_seen    = 0;
        branches_seen = 0;
        for (int a = 0; a < 65536; a++) begin
            data_mem[a] = lc4_pkg::word_t'(a) ^ 16'hA5C3;
        end
        repeat (8) @(posedge gwe);
        #2;
        rst_n = 1'b1;
        @(negedge gwe);
        check_value("first fetch pc", `LC4_RESET_PC, cur_pc);
    end

endmodule

/* bench/lc4_pipeline_properties.sv */
`timescale 1ns/1ns

module lc4_pipeline_properties (
    input logic               gwe,
    input logic               i_rst_n,
    input lc4_pkg::dmem_req_t i_dmem,
    input lc4_pkg::trace_t    i_trace
);

    // once a reset edge has been seen, no store strobe while reset stays low
    a_no_store_in_reset: assert property (
        @(posedge gwe) !i_rst_n |=> (!i_rst_n ? !i_dmem.we : 1'b1)
    ) else $error("data memory write strobe high during reset");

    // a bubble retires without touching any state
    a_quiet_bubble: assert property (
        @(posedge gwe) disable iff (!i_rst_n)
        (i_trace.stall != lc4_pkg::STALL_NONE) |->
            (!i_trace.regfile_we && !i_trace.nzp_we && !i_trace.dmem_we)
    ) else $error("bubble trace with a write enable set");

    // single issue never produces the pipe switch code
    a_no_pipe_stall: assert property (
        @(posedge gwe) disable iff (!i_rst_n)
        i_trace.stall != lc4_pkg::STALL_PIPE
    ) else $error("trace shows the reserved pipe stall code");

endmodule

/* hdl/lc4_pipeline.sv */
`timescale 1ns/1ns
`include "lc4_params.svh"

module lc4_pipeline (
    input  logic                gwe,
    input  logic                i_rst_n,
    output lc4_pkg::word_t      o_cur_pc,
    input  lc4_pkg::word_t      i_cur_insn,
    output lc4_pkg::dmem_req_t  o_dmem,
    input  lc4_pkg::word_t      i_dmem_data,
    output lc4_pkg::trace_t     o_trace
);

    lc4_pkg::word_t  pc;
    lc4_pkg::stage_t d_reg;
    lc4_pkg::stage_t x_reg;
    lc4_pkg::stage_t m_reg;
    lc4_pkg::stage_t w_reg;
    lc4_pkg::nzp_t   nzp_reg;

    // datapath registers along the stages
    lc4_pkg::word_t  x_rs_data;
    lc4_pkg::word_t  x_rt_data;
    lc4_pkg::word_t  m_result;
    lc4_pkg::word_t  m_rt_data;
    lc4_pkg::word_t  w_wdata;
    lc4_pkg::word_t  w_addr;
    lc4_pkg::word_t  w_dmem_data;
    lc4_pkg::nzp_t   w_nzp;

    lc4_pkg::ctrl_t  d_ctrl;
    lc4_pkg::word_t  rs_data;
    lc4_pkg::word_t  rt_data;
    lc4_pkg::word_t  rs_byp;
    lc4_pkg::word_t  rt_byp;
    lc4_pkg::word_t  alu_result;
    lc4_pkg::word_t  store_data;
    lc4_pkg::word_t  m_wdata;
    lc4_pkg::nzp_t   m_nzp;
    lc4_pkg::nzp_t   br_nzp;
    logic            load_stall;
    logic            br_taken;
    logic            m_mem;
    logic            w_mem;

    function automatic lc4_pkg::stage_t bubble(input lc4_pkg::stall_t code);
        lc4_pkg::stage_t s;
        s       = '0;
        s.stall = code;
        return s;
    endfunction

    function automatic lc4_pkg::nzp_t sign_bits(input lc4_pkg::word_t v);
        if (v[`LC4_WORD_W-1]) begin
            return 3'b100;
        end else if (v == '0) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

    lc4_decoder u_decoder (
        .i_insn (d_reg.insn),
        .o_ctrl (d_ctrl)
    );

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_rst_n   (i_rst_n),
        .i_rs      (d_ctrl.rs),
        .i_rt      (d_ctrl.rt),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data),
        .i_rd      (w_reg.ctrl.rd),
        .i_wdata   (w_wdata),
        .i_rd_we   (w_reg.ctrl.rd_we)
    );

    lc4_hazard_unit u_hazard (
        .i_d_ctrl     (d_ctrl),
        .i_x_ctrl     (x_reg.ctrl),
        .i_m_ctrl     (m_reg.ctrl),
        .i_w_ctrl     (w_reg.ctrl),
        .i_x_rs_data  (x_rs_data),
        .i_x_rt_data  (x_rt_data),
        .i_m_rt_data  (m_rt_data),
        .i_m_result   (m_result),
        .i_w_wdata    (w_wdata),
        .o_load_stall (load_stall),
        .o_rs_byp     (rs_byp),
        .o_rt_byp     (rt_byp),
        .o_store_data (store_data)
    );

    lc4_alu u_alu (
        .i_insn    (x_reg.insn),
        .i_pc      (x_reg.pc),
        .i_rs_data (rs_byp),
        .i_rt_data (rt_byp),
        .o_result  (alu_result)
    );

    // value leaving M, either ALU result or load data
    assign m_mem   = m_reg.ctrl.is_load || m_reg.ctrl.is_store;
    assign m_wdata = m_reg.ctrl.is_load ? i_dmem_data : m_result;
    assign m_nzp   = sign_bits(m_wdata);

    // branch in X sees the nzp that M is about to write
    assign br_nzp   = m_reg.ctrl.nzp_we ? m_nzp : nzp_reg;
    assign br_taken = x_reg.ctrl.is_branch && ((x_reg.insn[11:9] & br_nzp) != 3'b000);

    assign o_cur_pc = pc;

    always_comb begin
        o_dmem.we      = m_reg.ctrl.is_store;
        o_dmem.addr    = m_mem ? m_result : '0;
        o_dmem.towrite = m_reg.ctrl.is_store ? store_data : '0;
    end

    // fetch, decode and the stall/flush control
    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            pc    <= `LC4_RESET_PC;
            d_reg <= bubble(lc4_pkg::STALL_BRANCH);
            x_reg <= bubble(lc4_pkg::STALL_BRANCH);
        end else if (br_taken) begin
            // squash the two younger slots
            pc    <= alu_result;
            d_reg <= bubble(lc4_pkg::STALL_BRANCH);
            x_reg <= bubble(lc4_pkg::STALL_BRANCH);
        end else if (load_stall) begin
            x_reg <= bubble(lc4_pkg::STALL_LOAD);
        end else begin
            pc         <= pc + 1'b1;
            d_reg      <= '{pc: pc, insn: i_cur_insn, ctrl: '0, stall: lc4_pkg::STALL_NONE};
            x_reg      <= '{pc: d_reg.pc, insn: d_reg.insn, ctrl: d_ctrl, stall: d_reg.stall};
        end
    end

    always_ff @(posedge gwe) begin
        x_rs_data <= rs_data;
        x_rt_data <= rt_data;
    end

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            m_reg   <= bubble(lc4_pkg::STALL_BRANCH);
            w_reg   <= bubble(lc4_pkg::STALL_BRANCH);
            nzp_reg <= 3'b000;
        end else begin
            m_reg <= x_reg;
            w_reg <= m_reg;
            if (m_reg.ctrl.nzp_we) begin
                nzp_reg <= m_nzp;
            end
        end
    end

    always_ff @(posedge gwe) begin
        m_result    <= alu_result;
        m_rt_data   <= rt_byp;
        w_wdata     <= m_wdata;
        w_nzp       <= m_nzp;
        w_addr      <= m_result;
        w_dmem_data <= m_reg.ctrl.is_store ? store_data : i_dmem_data;
    end

    assign w_mem = w_reg.ctrl.is_load || w_reg.ctrl.is_store;

    // trace of the slot retiring from W
    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            o_trace       <= '0;
            o_trace.stall <= lc4_pkg::STALL_BRANCH;
        end else begin
            o_trace.stall      <= w_reg.stall;
            o_trace.pc         <= w_reg.pc;
            o_trace.insn       <= w_reg.insn;
            o_trace.regfile_we <= w_reg.ctrl.rd_we;
            o_trace.wsel       <= w_reg.ctrl.rd;
            o_trace.wdata      <= w_wdata;
            o_trace.nzp_we     <= w_reg.ctrl.nzp_we;
            o_trace.nzp_bits   <= w_nzp;
            o_trace.dmem_we    <= w_reg.ctrl.is_store;
            o_trace.dmem_addr  <= w_mem ? w_addr : '0;
            o_trace.dmem_data  <= w_mem ? w_dmem_data : '0;
        end
    end

endmodule

/* hdl/lc4_hazard_unit.sv */
`timescale 1ns/1ns

module lc4_hazard_unit (
    input  lc4_pkg::ctrl_t i_d_ctrl,
    input  lc4_pkg::ctrl_t i_x_ctrl,
    input  lc4_pkg::ctrl_t i_m_ctrl,
    input  lc4_pkg::ctrl_t i_w_ctrl,
    input  lc4_pkg::word_t i_x_rs_data,
    input  lc4_pkg::word_t i_x_rt_data,
    input  lc4_pkg::word_t i_m_rt_data,
    input  lc4_pkg::word_t i_m_result,
    input  lc4_pkg::word_t i_w_wdata,
    output logic           o_load_stall,
    output lc4_pkg::word_t o_rs_byp,
    output lc4_pkg::word_t o_rt_byp,
    output lc4_pkg::word_t o_store_data
);

    logic x_load;
    logic load_use;
    logic load_br;
    logic m_fwd;
    logic m_rs_hit;
    logic m_rt_hit;
    logic w_rs_hit;
    logic w_rt_hit;
    logic wm_hit;

    assign x_load = i_x_ctrl.is_load && i_x_ctrl.rd_we;

    // store data is left out, the WM path covers it
    assign load_use = x_load &&
                      ((i_d_ctrl.rs_re && i_d_ctrl.rs == i_x_ctrl.rd) ||
                       (i_d_ctrl.rt_re && i_d_ctrl.rt == i_x_ctrl.rd && !i_d_ctrl.is_store));

    // branch needs the nzp of the loaded value
    assign load_br = i_x_ctrl.is_load && i_x_ctrl.nzp_we && i_d_ctrl.is_branch;

    assign o_load_stall = load_use || load_br;

    // M holds an address for a load, never a usable result
    assign m_fwd = i_m_ctrl.rd_we && !i_m_ctrl.is_load;

    assign m_rs_hit = m_fwd && i_x_ctrl.rs_re && i_m_ctrl.rd == i_x_ctrl.rs;
    assign m_rt_hit = m_fwd && i_x_ctrl.rt_re && i_m_ctrl.rd == i_x_ctrl.rt;
    assign w_rs_hit = i_w_ctrl.rd_we && i_x_ctrl.rs_re && i_w_ctrl.rd == i_x_ctrl.rs;
    assign w_rt_hit = i_w_ctrl.rd_we && i_x_ctrl.rt_re && i_w_ctrl.rd == i_x_ctrl.rt;

    // MX before WX before the value read in decode
    assign o_rs_byp = m_rs_hit ? i_m_result :
                      w_rs_hit ? i_w_wdata  :
                      i_x_rs_data;
    assign o_rt_byp = m_rt_hit ? i_m_result :
                      w_rt_hit ? i_w_wdata  :
                      i_x_rt_data;

    // WM bypass, mainly a load feeding the next store's data
    assign wm_hit = i_m_ctrl.is_store && i_w_ctrl.rd_we && i_w_ctrl.rd == i_m_ctrl.rt;

    assign o_store_data = wm_hit ? i_w_wdata : i_m_rt_data;

endmodule

/* hdl/lc4_alu.sv */
`timescale 1ns/1ns
`include "lc4_params.svh"

module lc4_alu (
    input  lc4_pkg::word_t i_insn,
    input  lc4_pkg::word_t i_pc,
    input  lc4_pkg::word_t i_rs_data,
    input  lc4_pkg::word_t i_rt_data,
    output lc4_pkg::word_t o_result
);

    lc4_pkg::word_t imm5;
    lc4_pkg::word_t imm6;
    lc4_pkg::word_t imm9;

    // sign-extended immediates
    assign imm5 = {{(`LC4_WORD_W - 5){i_insn[4]}}, i_insn[4:0]};
    assign imm6 = {{(`LC4_WORD_W - 6){i_insn[5]}}, i_insn[5:0]};
    assign imm9 = {{(`LC4_WORD_W - 9){i_insn[8]}}, i_insn[8:0]};

    always_comb begin
        case (i_insn[15:12])
            `LC4_OP_ARITH: begin
                if (i_insn[5]) begin
                    o_result = i_rs_data + imm5;
                end else if (i_insn[5:3] == `LC4_SUB_SUB) begin
                    o_result = i_rs_data - i_rt_data;
                end else begin
                    o_result = i_rs_data + i_rt_data;
                end
            end
            `LC4_OP_AND:   o_result = i_rs_data & i_rt_data;
            `LC4_OP_CONST: o_result = imm9;
            // effective address for both memory ops
            `LC4_OP_LDR,
            `LC4_OP_STR:   o_result = i_rs_data + imm6;
            `LC4_OP_BR:    o_result = i_pc + 1'b1 + imm9;
            default:       o_result = '0;
        endcase
    end

endmodule

/* hdl/lc4_regfile.sv */
`timescale 1ns/1ns
`include "lc4_params.svh"

module lc4_regfile (
    input  logic               gwe,
    input  logic               i_rst_n,
    input  lc4_pkg::reg_sel_t  i_rs,
    input  lc4_pkg::reg_sel_t  i_rt,
    output lc4_pkg::word_t     o_rs_data,
    output lc4_pkg::word_t     o_rt_data,
    input  lc4_pkg::reg_sel_t  i_rd,
    input  lc4_pkg::word_t     i_wdata,
    input  logic               i_rd_we
);

    lc4_pkg::word_t regs [`LC4_NUM_REGS];

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `LC4_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_we) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign o_rs_data = (i_rd_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
    assign o_rt_data = (i_rd_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

/* hdl/lc4_decoder.sv */
`timescale 1ns/1ns
`include "lc4_params.svh"

module lc4_decoder (
    input  lc4_pkg::word_t i_insn,
    output lc4_pkg::ctrl_t o_ctrl
);

    logic [3:0] opcode;
    logic [2:0] subop;

    assign opcode = i_insn[15:12];
    assign subop  = i_insn[5:3];

    always_comb begin
        // anything not matched below stays a NOP
        o_ctrl = '0;
        case (opcode)
            `LC4_OP_BR: begin
                // nzp 000 can never be taken
                o_ctrl.is_branch = (i_insn[11:9] != 3'b000);
            end
            `LC4_OP_ARITH: begin
                if (i_insn[5] || subop == `LC4_SUB_ADD || subop == `LC4_SUB_SUB) begin
                    o_ctrl.rs     = i_insn[8:6];
                    o_ctrl.rt     = i_insn[2:0];
                    o_ctrl.rd     = i_insn[11:9];
                    o_ctrl.rs_re  = 1'b1;
                    // immediate form has no rt
                    o_ctrl.rt_re  = ~i_insn[5];
                    o_ctrl.rd_we  = 1'b1;
                    o_ctrl.nzp_we = 1'b1;
                end
            end
            `LC4_OP_AND: begin
                // register AND only
                if (subop == 3'b000) begin
                    o_ctrl.rs     = i_insn[8:6];
                    o_ctrl.rt     = i_insn[2:0];
                    o_ctrl.rd     = i_insn[11:9];
                    o_ctrl.rs_re  = 1'b1;
                    o_ctrl.rt_re  = 1'b1;
                    o_ctrl.rd_we  = 1'b1;
                    o_ctrl.nzp_we = 1'b1;
                end
            end
            `LC4_OP_LDR: begin
                o_ctrl.rs      = i_insn[8:6];
                o_ctrl.rd      = i_insn[11:9];
                o_ctrl.rs_re   = 1'b1;
                o_ctrl.rd_we   = 1'b1;
                o_ctrl.nzp_we  = 1'b1;
                o_ctrl.is_load = 1'b1;
            end
            `LC4_OP_STR: begin
                // data register sits in the rd field
                o_ctrl.rs       = i_insn[8:6];
                o_ctrl.rt       = i_insn[11:9];
                o_ctrl.rs_re    = 1'b1;
                o_ctrl.rt_re    = 1'b1;
                o_ctrl.is_store = 1'b1;
            end
            `LC4_OP_CONST: begin
                o_ctrl.rd     = i_insn[11:9];
                o_ctrl.rd_we  = 1'b1;
                o_ctrl.nzp_we = 1'b1;
            end
            default: begin
                o_ctrl = '0;
            end
        endcase
    end

endmodule

/* hdl/lc4_pkg.sv */
package lc4_pkg;

`include "lc4_params.svh"

    typedef logic [`LC4_WORD_W-1:0] word_t;
    typedef logic [`LC4_REG_SEL_W-1:0] reg_sel_t;
    // n, z, p from msb to lsb
    typedef logic [2:0] nzp_t;

    // trace stall codes, STALL_PIPE only had meaning for dual issue
    typedef enum logic [1:0] {
        STALL_NONE   = 2'd0,
        STALL_PIPE   = 2'd1,
        STALL_BRANCH = 2'd2,
        STALL_LOAD   = 2'd3
    } stall_t;

    typedef struct packed {
        reg_sel_t rs;
        reg_sel_t rt;
        reg_sel_t rd;
        logic     rs_re;
        logic     rt_re;
        logic     rd_we;
        logic     nzp_we;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
    } ctrl_t;

    typedef struct packed {
        word_t  pc;
        word_t  insn;
        ctrl_t  ctrl;
        stall_t stall;
    } stage_t;

    typedef struct packed {
        logic  we;
        word_t addr;
        word_t towrite;
    } dmem_req_t;

    // one record per retired slot, taken from writeback
    typedef struct packed {
        stall_t   stall;
        word_t    pc;
        word_t    insn;
        logic     regfile_we;
        reg_sel_t wsel;
        word_t    wdata;
        logic     nzp_we;
        nzp_t     nzp_bits;
        logic     dmem_we;
        word_t    dmem_addr;
        word_t    dmem_data;
    } trace_t;

endpackage

/* hdl/lc4_params.svh */
`ifndef LC4_PARAMS_SVH
`define LC4_PARAMS_SVH

// datapath widths
`define LC4_WORD_W    16
`define LC4_REG_SEL_W 3
`define LC4_NUM_REGS  8

// first fetch address after reset
`define LC4_RESET_PC  16'h8200

// primary opcodes, insn[15:12]
`define LC4_OP_BR     4'd0
`define LC4_OP_ARITH  4'd1
`define LC4_OP_AND    4'd5
`define LC4_OP_LDR    4'd6
`define LC4_OP_STR    4'd7
`define LC4_OP_CONST  4'd9

// arithmetic sub-opcodes, insn[5:3]
`define LC4_SUB_ADD   3'd0
`define LC4_SUB_SUB   3'd2

`endif
